// ==== source/vlsu_pkg.sv ====
/*
 * Vector load/store unit package.
 * Shared widths, data types and enums for the unit-stride
 * load/store path between the vector side and four data banks.
 */
package vlsu_pkg;

    localparam int NUM_BANKS = 4;
    localparam int WORD_W    = 32;
    localparam int BEAT_W    = 128;
    localparam int GROUP_W   = 512;
    localparam int MAX_BEATS = 4;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BEAT_W-1:0]  beat_t;
    typedef logic [GROUP_W-1:0] vreg_group_t;

    // 0 to MAX_BEATS inclusive
    typedef logic [$clog2(MAX_BEATS+1)-1:0] beat_cnt_t;

    typedef enum logic {
        VLSU_LOAD  = 1'b0,
        VLSU_STORE = 1'b1
    } vlsu_op_e;

    typedef enum logic [1:0] {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2
    } lmul_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        RESP = 2'd2
    } ctrl_state_e;

endpackage

// ==== source/bank_req_if.sv ====
/*
 * Bank request interface.
 * Carries one sequencer's per-bank address, write data and write
 * enable to the bank port, and the read return back.
 */
`timescale 1ns/1ps

interface bank_req_if #(
    parameter int ADDR_W = 10
);
    import vlsu_pkg::*;

    logic              active;
    logic [ADDR_W-1:0] addr [NUM_BANKS];
    word_t             wdata [NUM_BANKS];
    logic              we;

    // read return, one full beat at a time
    word_t             rdata [NUM_BANKS];
    logic              rvalid;

    modport requester (
        output active,
        output addr,
        output wdata,
        output we,
        input  rdata,
        input  rvalid
    );

    modport port (
        input  active,
        input  addr,
        input  wdata,
        input  we,
        output rdata,
        output rvalid
    );

endinterface

// ==== source/seq_ctrl_if.sv ====
/*
 * Sequencer control interface.
 * The command controller starts a sequencer with a one-cycle pulse
 * plus address, beat count and store group; the sequencer answers
 * with a one-cycle done and the assembled load group.
 */
`timescale 1ns/1ps

interface seq_ctrl_if #(
    parameter int ADDR_W = 10
);
    import vlsu_pkg::*;

    logic              start;
    logic [ADDR_W-1:0] addr;
    beat_cnt_t         beats;
    vreg_group_t       store_data;

    logic              done;
    vreg_group_t       load_data;

    modport ctrl (
        output start,
        output addr,
        output beats,
        output store_data,
        input  done,
        input  load_data
    );

    modport seq (
        input  start,
        input  addr,
        input  beats,
        input  store_data,
        output done,
        output load_data
    );

endinterface

// ==== source/vlsu_cmd_ctrl.sv ====
/*
 * Command controller.
 * Accepts one command at a time, converts LMUL to a beat count and
 * starts the load or store sequencer. The completing sequencer's
 * result is held in the response register until it is taken.
 */
`timescale 1ns/1ps

module vlsu_cmd_ctrl #(
    parameter int ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  cmd_valid,
    input  vlsu_pkg::vlsu_op_e    cmd_op,
    input  vlsu_pkg::lmul_e       cmd_lmul,
    input  logic [ADDR_W-1:0]     cmd_addr,
    input  vlsu_pkg::vreg_group_t cmd_store_data,
    input  logic                  resp_ready,
    output logic                  cmd_ready,
    output logic                  resp_valid,
    output vlsu_pkg::vlsu_op_e    resp_op,
    output vlsu_pkg::vreg_group_t resp_load_data,
    seq_ctrl_if.ctrl              load_ctrl,
    seq_ctrl_if.ctrl              store_ctrl
);
    import vlsu_pkg::*;

    ctrl_state_e       state;
    vlsu_op_e          op_q;
    logic              load_start_q;
    logic              store_start_q;
    logic [ADDR_W-1:0] addr_q;
    beat_cnt_t         beats_q;
    vreg_group_t       store_data_q;
    vreg_group_t       resp_data_q;
    logic              accept;
    logic              seq_done;

    function automatic beat_cnt_t lmul_to_beats(lmul_e lmul);
        case (lmul)
            LMUL_2:  return beat_cnt_t'(2);
            LMUL_4:  return beat_cnt_t'(4);
            default: return beat_cnt_t'(1);
        endcase
    endfunction

    assign cmd_ready = (state == IDLE);
    assign accept    = cmd_valid && cmd_ready;
    assign seq_done  = load_ctrl.done || store_ctrl.done;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state         <= IDLE;
            op_q          <= VLSU_LOAD;
            load_start_q  <= 1'b0;
            store_start_q <= 1'b0;
        end else begin
            // start is a single-cycle pulse
            load_start_q  <= 1'b0;
            store_start_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state         <= BUSY;
                        op_q          <= cmd_op;
                        load_start_q  <= (cmd_op == VLSU_LOAD);
                        store_start_q <= (cmd_op == VLSU_STORE);
                    end
                end
                BUSY: begin
                    if (seq_done) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (resp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q       <= cmd_addr;
            beats_q      <= lmul_to_beats(cmd_lmul);
            store_data_q <= cmd_store_data;
        end
        // store sequencer returns an all-zero group
        if (state == BUSY && seq_done) begin
            resp_data_q <= load_ctrl.done ? load_ctrl.load_data : store_ctrl.load_data;
        end
    end

    assign load_ctrl.start       = load_start_q;
    assign load_ctrl.addr        = addr_q;
    assign load_ctrl.beats       = beats_q;
    assign load_ctrl.store_data  = '0;

    assign store_ctrl.start      = store_start_q;
    assign store_ctrl.addr       = addr_q;
    assign store_ctrl.beats      = beats_q;
    assign store_ctrl.store_data = store_data_q;

    assign resp_valid     = (state == RESP);
    assign resp_op        = op_q;
    assign resp_load_data = resp_data_q;

endmodule

// ==== source/vlsu_load_seq.sv ====
/*
 * Unit-stride load sequencer.
 * Issues one read beat per cycle at A+4k+i, then collects the
 * returned beats into their slots of the register group. Issue and
 * return are counted separately so reads overlap.
 */
`timescale 1ns/1ps

module vlsu_load_seq #(
    parameter int ADDR_W = 10
) (
    input  logic         clk,
    input  logic         nrst,
    seq_ctrl_if.seq      ctrl,
    bank_req_if.requester bank
);
    import vlsu_pkg::*;

    localparam int SLOT_W = $clog2(MAX_BEATS);

    logic [ADDR_W-1:0] addr_q;
    beat_cnt_t         issue_left;
    beat_cnt_t         ret_idx;
    beat_cnt_t         ret_total;
    vreg_group_t       group_q;
    vreg_group_t       group_nxt;
    beat_t             ret_beat;
    logic [SLOT_W-1:0] slot;

    assign bank.active = (issue_left != '0);
    assign bank.we     = 1'b0;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank.addr[i]  = addr_q + ADDR_W'(i);
            bank.wdata[i] = '0;
        end
    end

    // bank 0 is the low word of a beat
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            ret_beat[i*WORD_W +: WORD_W] = bank.rdata[i];
        end
    end

    assign slot = ret_idx[SLOT_W-1:0];

    always_comb begin
        group_nxt = group_q;
        if (bank.rvalid) begin
            group_nxt[slot*BEAT_W +: BEAT_W] = ret_beat;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            issue_left <= '0;
            ret_idx    <= '0;
            ret_total  <= '0;
        end else if (ctrl.start) begin
            issue_left <= ctrl.beats;
            ret_idx    <= '0;
            ret_total  <= ctrl.beats;
        end else begin
            if (issue_left != '0) begin
                issue_left <= issue_left - beat_cnt_t'(1);
            end
            if (bank.rvalid) begin
                ret_idx <= ret_idx + beat_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            addr_q  <= ctrl.addr;
            group_q <= '0;
        end else begin
            if (issue_left != '0) begin
                addr_q <= addr_q + ADDR_W'(NUM_BANKS);
            end
            group_q <= group_nxt;
        end
    end

    // last return completes the command in the same cycle
    assign ctrl.done      = bank.rvalid && (ret_idx + beat_cnt_t'(1) == ret_total);
    assign ctrl.load_data = group_nxt;

endmodule

// ==== source/vlsu_store_seq.sv ====
/*
 * Unit-stride store sequencer.
 * Captures the register group on start and writes it out one beat
 * per cycle, four words to the four banks, shifting the group down
 * after each beat.
 */
`timescale 1ns/1ps

module vlsu_store_seq #(
    parameter int ADDR_W = 10
) (
    input  logic          clk,
    input  logic          nrst,
    seq_ctrl_if.seq       ctrl,
    bank_req_if.requester bank
);
    import vlsu_pkg::*;

    logic [ADDR_W-1:0] addr_q;
    vreg_group_t       data_q;
    beat_cnt_t         issue_left;
    logic              last_beat;
    logic              wr_pend;
    logic              done_q;

    assign bank.active = (issue_left != '0);
    assign bank.we     = bank.active;
    assign last_beat   = (issue_left == beat_cnt_t'(1));

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank.addr[i]  = addr_q + ADDR_W'(i);
            bank.wdata[i] = data_q[i*WORD_W +: WORD_W];
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            issue_left <= '0;
            wr_pend    <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            if (ctrl.start) begin
                issue_left <= ctrl.beats;
            end else if (issue_left != '0) begin
                issue_left <= issue_left - beat_cnt_t'(1);
            end
            // one stage for the bank port register, one for the write
            wr_pend <= last_beat;
            done_q  <= wr_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            addr_q <= ctrl.addr;
            data_q <= ctrl.store_data;
        end else if (issue_left != '0) begin
            addr_q <= addr_q + ADDR_W'(NUM_BANKS);
            data_q <= data_q >> BEAT_W;
        end
    end

    assign ctrl.done      = done_q;
    assign ctrl.load_data = '0;

endmodule

// ==== source/vlsu_bank_port.sv ====
/*
 * Bank port.
 * Muxes the active sequencer onto the four banks through an output
 * register and tracks reads in flight so the returned words come
 * back to the load sequencer with rvalid.
 */
`timescale 1ns/1ps

module vlsu_bank_port #(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              nrst,
    input  vlsu_pkg::word_t   bank_rdata [vlsu_pkg::NUM_BANKS],
    output logic [ADDR_W-1:0] bank_addr [vlsu_pkg::NUM_BANKS],
    output vlsu_pkg::word_t   bank_wdata [vlsu_pkg::NUM_BANKS],
    output logic              bank_we,
    bank_req_if.port          load_req,
    bank_req_if.port          store_req
);
    import vlsu_pkg::*;

    logic [ADDR_W-1:0] addr_nxt [NUM_BANKS];
    word_t             wdata_nxt [NUM_BANKS];
    logic              we_nxt;
    logic              rd_issue;
    logic [1:0]        rd_pipe;
    logic              rvalid_q;
    word_t             rdata_q [NUM_BANKS];

    always_comb begin
        if (load_req.active) begin
            addr_nxt  = load_req.addr;
            wdata_nxt = load_req.wdata;
            we_nxt    = load_req.we;
        end else if (store_req.active) begin
            addr_nxt  = store_req.addr;
            wdata_nxt = store_req.wdata;
            we_nxt    = store_req.we;
        end else begin
            addr_nxt  = '{default: '0};
            wdata_nxt = '{default: '0};
            we_nxt    = 1'b0;
        end
    end

    assign rd_issue = load_req.active && !load_req.we;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bank_addr  <= '{default: '0};
            bank_wdata <= '{default: '0};
            bank_we    <= 1'b0;
            rd_pipe    <= '0;
            rvalid_q   <= 1'b0;
        end else begin
            bank_addr  <= addr_nxt;
            bank_wdata <= wdata_nxt;
            bank_we    <= we_nxt;
            // address at banks, then data at bank_rdata
            rd_pipe    <= {rd_pipe[0], rd_issue};
            rvalid_q   <= rd_pipe[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pipe[1]) begin
            rdata_q <= bank_rdata;
        end
    end

    assign load_req.rdata   = rdata_q;
    assign load_req.rvalid  = rvalid_q;
    assign store_req.rdata  = '{default: '0};
    assign store_req.rvalid = 1'b0;

endmodule

// ==== source/vlsu_top.sv ====
/*
 * Vector load/store data unit, top level.
 * Moves one vector register group between the vector side and four
 * 32-bit data banks with unit-stride loads and stores.
 */
`timescale 1ns/1ps

module vlsu_top #(
    parameter int ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  vlsu_pkg::vlsu_op_e    cmd_op,
    input  vlsu_pkg::lmul_e       cmd_lmul,
    input  logic [ADDR_W-1:0]     cmd_addr,
    input  vlsu_pkg::vreg_group_t cmd_store_data,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output vlsu_pkg::vlsu_op_e    resp_op,
    output vlsu_pkg::vreg_group_t resp_load_data,
    output logic [ADDR_W-1:0]     bank_addr [vlsu_pkg::NUM_BANKS],
    output vlsu_pkg::word_t       bank_wdata [vlsu_pkg::NUM_BANKS],
    output logic                  bank_we,
    input  vlsu_pkg::word_t       bank_rdata [vlsu_pkg::NUM_BANKS]
);

    seq_ctrl_if #(.ADDR_W(ADDR_W)) load_ctrl_if ();
    seq_ctrl_if #(.ADDR_W(ADDR_W)) store_ctrl_if ();
    bank_req_if #(.ADDR_W(ADDR_W)) load_req_if ();
    bank_req_if #(.ADDR_W(ADDR_W)) store_req_if ();

    vlsu_cmd_ctrl #(
        .ADDR_W(ADDR_W)
    ) vlsu_cmd_ctrl_inst (
        .clk           (clk),
        .nrst          (nrst),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_lmul      (cmd_lmul),
        .cmd_addr      (cmd_addr),
        .cmd_store_data(cmd_store_data),
        .resp_ready    (resp_ready),
        .cmd_ready     (cmd_ready),
        .resp_valid    (resp_valid),
        .resp_op       (resp_op),
        .resp_load_data(resp_load_data),
        .load_ctrl     (load_ctrl_if),
        .store_ctrl    (store_ctrl_if)
    );

    // only one sequencer is started per command
    vlsu_load_seq #(
        .ADDR_W(ADDR_W)
    ) vlsu_load_seq_inst (
        .clk (clk),
        .nrst(nrst),
        .ctrl(load_ctrl_if),
        .bank(load_req_if)
    );

    vlsu_store_seq #(
        .ADDR_W(ADDR_W)
    ) vlsu_store_seq_inst (
        .clk (clk),
        .nrst(nrst),
        .ctrl(store_ctrl_if),
        .bank(store_req_if)
    );

    vlsu_bank_port #(
        .ADDR_W(ADDR_W)
    ) vlsu_bank_port_inst (
        .clk       (clk),
        .nrst      (nrst),
        .bank_rdata(bank_rdata),
        .bank_addr (bank_addr),
        .bank_wdata(bank_wdata),
        .bank_we   (bank_we),
        .load_req  (load_req_if),
        .store_req (store_req_if)
    );

endmodule

// ==== verif/vlsu_tests.svh ====
/*
 * Directed tests for the vector load/store unit.
 * Command and response helpers, the expected memory image and the
 * reset, store, load, round trip and back-pressure tests.
 */
`ifndef VLSU_TESTS_SVH
`define VLSU_TESTS_SVH

function automatic int lmul_beats(input lmul_e lmul);
    case (lmul)
        LMUL_2:  return 2;
        LMUL_4:  return 4;
        default: return 1;
    endcase
endfunction

function automatic vreg_group_t random_group();
    vreg_group_t g;
    for (int w = 0; w < GROUP_W / WORD_W; w++) begin
        g[w*WORD_W +: WORD_W] = $urandom;
    end
    return g;
endfunction

function automatic logic [ADDR_W-1:0] random_addr();
    return ADDR_W'($urandom_range(MEM_WORDS - NUM_BANKS * MAX_BEATS, 0));
endfunction

task automatic fill_memory();
    word_t w;
    for (int a = 0; a < MEM_WORDS; a++) begin
        w          = $urandom;
        mem[a]    <= w;
        exp_mem[a] = w;
    end
endtask

// word 4k+i of a group sits at A+4k+i
function automatic vreg_group_t expected_load(input logic [ADDR_W-1:0] addr,
                                              input lmul_e lmul);
    vreg_group_t g;
    g = '0;
    for (int w = 0; w < NUM_BANKS * lmul_beats(lmul); w++) begin
        g[w*WORD_W +: WORD_W] = exp_mem[addr + ADDR_W'(w)];
    end
    return g;
endfunction

task automatic write_expected(input logic [ADDR_W-1:0] addr, input lmul_e lmul,
                              input vreg_group_t data);
    for (int w = 0; w < NUM_BANKS * lmul_beats(lmul); w++) begin
        exp_mem[addr + ADDR_W'(w)] = data[w*WORD_W +: WORD_W];
    end
endtask

function automatic vreg_group_t keep_beats(input vreg_group_t data, input lmul_e lmul);
    vreg_group_t g;
    g = '0;
    for (int w = 0; w < NUM_BANKS * lmul_beats(lmul); w++) begin
        g[w*WORD_W +: WORD_W] = data[w*WORD_W +: WORD_W];
    end
    return g;
endfunction

task automatic compare_memory(input string name);
    for (int a = 0; a < MEM_WORDS; a++) begin
        check_word($sformatf("%s word %0d", name, a), exp_mem[a], mem[a]);
    end
endtask

task automatic run_cmd(input vlsu_op_e op, input lmul_e lmul,
                       input logic [ADDR_W-1:0] addr, input vreg_group_t data);
    int waited;
    waited = 0;
    @(posedge clk);
    cmd_valid      <= 1'b1;
    cmd_op         <= op;
    cmd_lmul       <= lmul;
    cmd_addr       <= addr;
    cmd_store_data <= data;
    @(negedge clk);
    while (!cmd_ready) begin
        waited++;
        if (waited > TIMEOUT) begin
            $display("cmd_ready never came high for a new command");
            abort_run();
        end
        @(negedge clk);
    end
    // accepted on this edge
    @(posedge clk);
    cmd_valid <= 1'b0;
endtask

task automatic wait_resp(input string name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!resp_valid) begin
        waited++;
        if (waited > TIMEOUT) begin
            $display("no response arrived in %s", name);
            abort_run();
        end
        @(negedge clk);
    end
endtask

task automatic take_resp(input string name);
    @(posedge clk);
    resp_ready <= 1'b1;
    @(posedge clk);
    resp_ready <= 1'b0;
    @(negedge clk);
    check_bit({name, " resp_valid after take"}, 1'b0, resp_valid);
endtask

task automatic reset_state();
    @(negedge clk);
    check_bit("reset cmd_ready", 1'b1, cmd_ready);
    check_bit("reset resp_valid", 1'b0, resp_valid);
    check_bit("reset bank_we", 1'b0, bank_we);
    for (int i = 0; i < NUM_BANKS; i++) begin
        check_word($sformatf("reset bank_addr %0d", i), '0, word_t'(bank_addr[i]));
    end
endtask

task automatic store_each_lmul();
    lmul_e             lmuls [3] = '{LMUL_1, LMUL_2, LMUL_4};
    logic [ADDR_W-1:0] addr;
    vreg_group_t       data;
    string             name;
    for (int j = 0; j < 3; j++) begin
        addr = random_addr();
        data = random_group();
        name = $sformatf("store lmul %0d", lmul_beats(lmuls[j]));
        run_cmd(VLSU_STORE, lmuls[j], addr, data);
        wait_resp(name);
        check_op(name, VLSU_STORE, resp_op);
        check_group(name, '0, resp_load_data);
        take_resp(name);
        write_expected(addr, lmuls[j], data);
        compare_memory(name);
    end
endtask

task automatic load_each_lmul();
    lmul_e             lmuls [3] = '{LMUL_1, LMUL_2, LMUL_4};
    logic [ADDR_W-1:0] addr;
    string             name;
    fill_memory();
    for (int j = 0; j < 3; j++) begin
        addr = random_addr();
        name = $sformatf("load lmul %0d", lmul_beats(lmuls[j]));
        run_cmd(VLSU_LOAD, lmuls[j], addr, random_group());
        wait_resp(name);
        check_op(name, VLSU_LOAD, resp_op);
        check_group(name, expected_load(addr, lmuls[j]), resp_load_data);
        take_resp(name);
        compare_memory(name);
    end
endtask

task automatic store_load_round_trip();
    lmul_e             lmuls [3] = '{LMUL_4, LMUL_2, LMUL_1};
    logic [ADDR_W-1:0] addr;
    vreg_group_t       data;
    string             name;
    for (int j = 0; j < 3; j++) begin
        addr = random_addr();
        data = random_group();
        name = $sformatf("round trip lmul %0d", lmul_beats(lmuls[j]));
        run_cmd(VLSU_STORE, lmuls[j], addr, data);
        wait_resp(name);
        take_resp(name);
        write_expected(addr, lmuls[j], data);
        run_cmd(VLSU_LOAD, lmuls[j], addr, '0);
        wait_resp(name);
        check_op(name, VLSU_LOAD, resp_op);
        check_group(name, keep_beats(data, lmuls[j]), resp_load_data);
        take_resp(name);
    end
endtask

task automatic hold_response();
    logic [ADDR_W-1:0] addr;
    vreg_group_t       held;
    addr = random_addr();
    run_cmd(VLSU_LOAD, LMUL_4, addr, '0);
    wait_resp("back-pressure");
    held = resp_load_data;
    // response held while resp_ready stays low
    repeat (6) begin
        @(negedge clk);
        check_bit("back-pressure resp_valid", 1'b1, resp_valid);
        check_bit("back-pressure cmd_ready", 1'b0, cmd_ready);
        check_bit("back-pressure bank_we", 1'b0, bank_we);
        check_op("back-pressure resp_op", VLSU_LOAD, resp_op);
        check_group("back-pressure stable data", held, resp_load_data);
    end
    check_group("back-pressure data", expected_load(addr, LMUL_4), resp_load_data);
    take_resp("back-pressure");
    @(negedge clk);
    check_bit("back-pressure cmd_ready after take", 1'b1, cmd_ready);
endtask

`endif

// ==== verif/vlsu_tb.sv ====
/*
 * Testbench for the vector load/store unit.
 * Clock, reset, DUT, a flat word memory shared by the four bank
 * ports with one cycle of read latency, and the compare tasks.
 */
`timescale 1ns/1ps

module vlsu_tb;
    import vlsu_pkg::*;

    localparam int ADDR_W    = 10;
    localparam int MEM_WORDS = 1 << ADDR_W;
    localparam int TIMEOUT   = 200;

    logic              clk;
    logic              nrst;
    logic              cmd_valid;
    logic              cmd_ready;
    vlsu_op_e          cmd_op;
    lmul_e             cmd_lmul;
    logic [ADDR_W-1:0] cmd_addr;
    vreg_group_t       cmd_store_data;
    logic              resp_valid;
    logic              resp_ready;
    vlsu_op_e          resp_op;
    vreg_group_t       resp_load_data;
    logic [ADDR_W-1:0] bank_addr [NUM_BANKS];
    word_t             bank_wdata [NUM_BANKS];
    logic              bank_we;
    word_t             bank_rdata [NUM_BANKS];

    // bank memory and its expected image
    word_t             mem [MEM_WORDS];
    word_t             exp_mem [MEM_WORDS];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    vlsu_top #(
        .ADDR_W(ADDR_W)
    ) vlsu_top_inst (
        .clk           (clk),
        .nrst          (nrst),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_op        (cmd_op),
        .cmd_lmul      (cmd_lmul),
        .cmd_addr      (cmd_addr),
        .cmd_store_data(cmd_store_data),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_op       (resp_op),
        .resp_load_data(resp_load_data),
        .bank_addr     (bank_addr),
        .bank_wdata    (bank_wdata),
        .bank_we       (bank_we),
        .bank_rdata    (bank_rdata)
    );

    // synchronous banks with one cycle of read latency
    always @(posedge clk) begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_we) begin
                mem[bank_addr[i]] <= bank_wdata[i];
            end
            bank_rdata[i] <= mem[bank_addr[i]];
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_group(input string name, input vreg_group_t exp,
                               input vreg_group_t act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_op(input string name, input vlsu_op_e exp, input vlsu_op_e act);
        if (exp !== act) begin
            $display("Mismatch %s expected %s actual %s", name, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    `include "vlsu_tests.svh"

    initial begin
        void'($urandom(67));
        nrst           = 1'b0;
        cmd_valid      = 1'b0;
        cmd_op         = VLSU_LOAD;
        cmd_lmul       = LMUL_1;
        cmd_addr       = '0;
        cmd_store_data = '0;
        resp_ready     = 1'b0;
        bank_rdata     = '{default: '0};
        fill_memory();
        repeat (3) @(posedge clk);
        nrst <= 1'b1;
        reset_state();
        store_each_lmul();
        load_each_lmul();
        store_load_round_trip();
        hold_response();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== vlsu.f ====
+incdir+verif
source/vlsu_pkg.sv
source/bank_req_if.sv
source/seq_ctrl_if.sv
source/vlsu_cmd_ctrl.sv
source/vlsu_load_seq.sv
source/vlsu_store_seq.sv
source/vlsu_bank_port.sv
source/vlsu_top.sv
verif/vlsu_tb.sv
